//--- flist.f
logic/tomasulo_pkg.sv
logic/issue_decode.sv
logic/reg_status_file.sv
logic/reservation_station.sv
logic/fp_exec_unit.sv
logic/cdb_arbiter.sv
logic/tomasulo_core.sv
tests/tb_tomasulo.sv

//--- logic/cdb_arbiter.sv
// Common data bus arbiter
// grants one pending unit result per cycle, multiply over add,
// and drives the winner onto the registered common data bus
// as a single-cycle pulse
`timescale 1ns/1ps

module cdb_arbiter import tomasulo_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     add_res_valid,
  input  reg_idx_t add_res_reg,
  input  data_t    add_res_value,
  input  logic     mul_res_valid,
  input  reg_idx_t mul_res_reg,
  input  data_t    mul_res_value,
  output logic     add_grant,
  output logic     mul_grant,
  output logic     cdb_valid,
  output reg_idx_t cdb_reg,
  output data_t    cdb_value
);

  // fixed priority, add waits whenever multiply is ready
  assign mul_grant = mul_res_valid;
  assign add_grant = add_res_valid && !mul_res_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= mul_grant || add_grant;
    end
  end

  // bus payload follows the grant, ignored while cdb_valid is low
  always_ff @(posedge clk) begin
    if (mul_grant) begin
      cdb_reg   <= mul_res_reg;
      cdb_value <= mul_res_value;
    end else if (add_grant) begin
      cdb_reg   <= add_res_reg;
      cdb_value <= add_res_value;
    end
  end

endmodule

//--- logic/fp_exec_unit.sv
// FP execution unit
// accepts one operation when idle, computes ADDF or MULTF,
// and presents the result LATENCY cycles later, holding it
// until the bus arbiter grants it
`timescale 1ns/1ps

module fp_exec_unit import tomasulo_pkg::*; #(
  parameter int LATENCY = 3
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ex_valid,
  input  opcode_e  ex_op,
  input  reg_idx_t ex_dest,
  input  data_t    ex_a,
  input  data_t    ex_b,
  input  logic     res_grant,
  output logic     idle,
  output logic     res_valid,
  output reg_idx_t res_reg,
  output data_t    res_value
);

  localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

  logic             busy;
  logic [CNT_W-1:0] cnt;
  logic             accept;
  data_t            result;

  assign idle   = !busy;
  assign accept = ex_valid && idle;

  // ADDF wraps, MULTF keeps the low word of the product
  always_comb begin
    case (ex_op)
      op_addf:  result = ex_a + ex_b;
      op_multf: result = ex_a * ex_b;
      default:  result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      res_valid <= 1'b0;
      cnt       <= '0;
    end else if (accept) begin
      busy <= 1'b1;
      cnt  <= CNT_W'(LATENCY - 1);
    end else if (busy && !res_valid) begin
      // count down the pipeline depth
      if (cnt == '0) begin
        res_valid <= 1'b1;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end else if (res_valid && res_grant) begin
      // result is on its way to the bus, free the unit
      res_valid <= 1'b0;
      busy      <= 1'b0;
    end
  end

  // result payload captured at accept
  always_ff @(posedge clk) begin
    if (accept) begin
      res_reg   <= ex_dest;
      res_value <= result;
    end
  end

endmodule

//--- logic/issue_decode.sv
// Instruction issue and decode
// acknowledges instructions on a four-phase req/ack port,
// stalls on a full station or a busy destination,
// and dispatches accepted ADDF/MULTF to the matching station
`timescale 1ns/1ps

module issue_decode import tomasulo_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     instr_req,
  input  instr_t   instr,
  output logic     instr_ack,
  input  logic     add_full,
  input  logic     mul_full,
  output reg_idx_t a_addr,
  output reg_idx_t b_addr,
  output reg_idx_t dest_addr,
  input  data_t    a_value,
  input  data_t    b_value,
  input  logic     a_busy,
  input  logic     b_busy,
  input  logic     dest_busy,
  output logic     add_disp_valid,
  output logic     mul_disp_valid,
  output opcode_e  disp_op,
  output reg_idx_t disp_dest,
  output reg_idx_t disp_a_reg,
  output reg_idx_t disp_b_reg,
  output data_t    disp_a_value,
  output data_t    disp_b_value,
  output logic     disp_a_busy,
  output logic     disp_b_busy,
  output logic     mark_valid,
  output reg_idx_t mark_reg
);

  opcode_e dec_op;
  logic    dest_zero;
  logic    station_ok;
  logic    accept;
  logic    dispatch;

  // field split, register file reads go straight out
  assign dest_addr = instr[8:6];
  assign a_addr    = instr[5:3];
  assign b_addr    = instr[2:0];
  assign dest_zero = (dest_addr == '0);

  // unknown codes behave as nop
  always_comb begin
    case (instr[11:9])
      op_addf:  dec_op = op_addf;
      op_multf: dec_op = op_multf;
      default:  dec_op = op_nop;
    endcase
  end

  // nop needs no station slot
  always_comb begin
    case (dec_op)
      op_addf:  station_ok = !add_full;
      op_multf: station_ok = !mul_full;
      default:  station_ok = 1'b1;
    endcase
  end

  // hold off while the destination still waits for a result,
  // so a register has at most one producer in flight
  assign accept = instr_req && !instr_ack && station_ok && (dest_zero || !dest_busy);

  // results for r0 are dropped, so such work is never dispatched
  assign dispatch       = accept && (dec_op != op_nop) && !dest_zero;
  assign add_disp_valid = dispatch && (dec_op == op_addf);
  assign mul_disp_valid = dispatch && (dec_op == op_multf);

  assign disp_op      = dec_op;
  assign disp_dest    = dest_addr;
  assign disp_a_reg   = a_addr;
  assign disp_b_reg   = b_addr;
  assign disp_a_value = a_value;
  assign disp_b_value = b_value;
  assign disp_a_busy  = a_busy;
  assign disp_b_busy  = b_busy;

  // destination turns busy on the dispatch edge
  assign mark_valid = dispatch;
  assign mark_reg   = dest_addr;

  // ack register is the whole handshake state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_ack <= 1'b0;
    end else if (accept) begin
      instr_ack <= 1'b1;
    end else if (instr_ack && !instr_req) begin
      // requester released, close the handshake
      instr_ack <= 1'b0;
    end
  end

endmodule

//--- logic/reg_status_file.sv
// Register file with busy status
// r1..r7 are writable from the common data bus, r0 reads zero;
// each register has a busy bit set at dispatch and cleared on
// its broadcast; all read ports are combinational
`timescale 1ns/1ps

module reg_status_file import tomasulo_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t a_addr,
  input  reg_idx_t b_addr,
  input  reg_idx_t dest_addr,
  input  reg_idx_t rd_addr,
  input  logic     mark_valid,
  input  reg_idx_t mark_reg,
  input  logic     cdb_valid,
  input  reg_idx_t cdb_reg,
  input  data_t    cdb_value,
  output data_t    a_value,
  output data_t    b_value,
  output logic     a_busy,
  output logic     b_busy,
  output logic     dest_busy,
  output data_t    rd_data
);

  // entry 0 is reset to zero and never written
  data_t               regs [NUM_REGS];
  logic [NUM_REGS-1:0] busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= (i == 0) ? '0 : REG_RESET_VALUE;
      end
      busy <= '0;
    end else begin
      // broadcast writes the value and retires the producer
      if (cdb_valid && (cdb_reg != '0)) begin
        regs[cdb_reg] <= cdb_value;
        busy[cdb_reg] <= 1'b0;
      end
      // new producer claims the register
      if (mark_valid && (mark_reg != '0)) begin
        busy[mark_reg] <= 1'b1;
      end
    end
  end

  // operand ports for decode
  assign a_value = regs[a_addr];
  assign b_value = regs[b_addr];
  assign a_busy  = busy[a_addr];
  assign b_busy  = busy[b_addr];

  // hazard check on the destination
  assign dest_busy = busy[dest_addr];

  // inspection port
  assign rd_data = regs[rd_addr];

endmodule

//--- logic/reservation_station.sv
// Reservation station
// age-ordered queue of DEPTH entries waiting for operands;
// pending operands are captured by register number from the
// common data bus, and the oldest ready entry issues to the
// unit when it is idle, with younger entries shifting down
`timescale 1ns/1ps

module reservation_station import tomasulo_pkg::*; #(
  parameter int DEPTH = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     disp_valid,
  input  opcode_e  disp_op,
  input  reg_idx_t disp_dest,
  input  reg_idx_t disp_a_reg,
  input  reg_idx_t disp_b_reg,
  input  data_t    disp_a_value,
  input  data_t    disp_b_value,
  input  logic     disp_a_busy,
  input  logic     disp_b_busy,
  input  logic     unit_idle,
  input  logic     cdb_valid,
  input  reg_idx_t cdb_reg,
  input  data_t    cdb_value,
  output logic     full,
  output logic     ex_valid,
  output opcode_e  ex_op,
  output reg_idx_t ex_dest,
  output data_t    ex_a,
  output data_t    ex_b
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef struct packed {
    opcode_e  op;
    reg_idx_t dest;
    reg_idx_t a_tag;
    reg_idx_t b_tag;
    logic     a_rdy;
    logic     b_rdy;
    data_t    a_val;
    data_t    b_val;
  } entry_t;

  // slot 0 is the oldest
  entry_t             ent_q [DEPTH];
  entry_t             ent_d [DEPTH];
  entry_t             snp   [DEPTH];
  logic [DEPTH-1:0]   valid_q;
  logic [DEPTH-1:0]   valid_d;
  logic [IDX_W-1:0]   sel;
  logic               found;
  logic               issue;

  // oldest entry with both operands in hand
  always_comb begin
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (!found && valid_q[i] && ent_q[i].a_rdy && ent_q[i].b_rdy) begin
        found = 1'b1;
        sel   = IDX_W'(i);
      end
    end
  end

  assign issue = found && unit_idle;

  // issue is combinational, the unit latches it on the edge
  assign ex_valid = issue;
  assign ex_op    = ent_q[sel].op;
  assign ex_dest  = ent_q[sel].dest;
  assign ex_a     = ent_q[sel].a_val;
  assign ex_b     = ent_q[sel].b_val;

  // queue is compacted once the last slot is taken
  assign full = valid_q[DEPTH-1];

  always_comb begin
    int cnt;
    cnt = 0;
    // snoop the bus for waiting operands
    for (int i = 0; i < DEPTH; i++) begin
      snp[i] = ent_q[i];
      if (cdb_valid && !snp[i].a_rdy && (cdb_reg == snp[i].a_tag)) begin
        snp[i].a_val = cdb_value;
        snp[i].a_rdy = 1'b1;
      end
      if (cdb_valid && !snp[i].b_rdy && (cdb_reg == snp[i].b_tag)) begin
        snp[i].b_val = cdb_value;
        snp[i].b_rdy = 1'b1;
      end
    end
    // drop the issued entry, younger ones move down a slot
    valid_d = '0;
    for (int i = 0; i < DEPTH; i++) begin
      ent_d[i] = snp[i];
    end
    for (int i = 0; i < DEPTH; i++) begin
      if (valid_q[i] && !(issue && (sel == IDX_W'(i)))) begin
        ent_d[cnt]   = snp[i];
        valid_d[cnt] = 1'b1;
        cnt++;
      end
    end
    // new entry goes behind the survivors
    if (disp_valid && (cnt < DEPTH)) begin
      ent_d[cnt].op    = disp_op;
      ent_d[cnt].dest  = disp_dest;
      ent_d[cnt].a_tag = disp_a_reg;
      ent_d[cnt].b_tag = disp_b_reg;
      // a broadcast in the dispatch cycle itself is taken directly
      ent_d[cnt].a_rdy = !disp_a_busy || (cdb_valid && (cdb_reg == disp_a_reg));
      ent_d[cnt].b_rdy = !disp_b_busy || (cdb_valid && (cdb_reg == disp_b_reg));
      ent_d[cnt].a_val = disp_a_busy ? cdb_value : disp_a_value;
      ent_d[cnt].b_val = disp_b_busy ? cdb_value : disp_b_value;
      valid_d[cnt]     = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // entry payload, meaningful only where valid_q is set
  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      ent_q[i] <= ent_d[i];
    end
  end

endmodule

//--- logic/tomasulo_core.sv
// Tomasulo FP issue core top level
// decode, register status file, add and multiply stations and
// units, and the common data bus arbiter
`timescale 1ns/1ps

module tomasulo_core import tomasulo_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     instr_req,
  input  instr_t   instr,
  output logic     instr_ack,
  output logic     cdb_valid,
  output reg_idx_t cdb_reg,
  output data_t    cdb_value,
  input  reg_idx_t rd_addr,
  output data_t    rd_data
);

  // decode to register file
  reg_idx_t a_addr;
  reg_idx_t b_addr;
  reg_idx_t dest_addr;
  data_t    a_value;
  data_t    b_value;
  logic     a_busy;
  logic     b_busy;
  logic     dest_busy;
  logic     mark_valid;
  reg_idx_t mark_reg;

  // dispatch bus shared by both stations
  logic     add_disp_valid;
  logic     mul_disp_valid;
  opcode_e  disp_op;
  reg_idx_t disp_dest;
  reg_idx_t disp_a_reg;
  reg_idx_t disp_b_reg;
  data_t    disp_a_value;
  data_t    disp_b_value;
  logic     disp_a_busy;
  logic     disp_b_busy;
  logic     add_full;
  logic     mul_full;

  // station to unit
  logic     add_ex_valid;
  opcode_e  add_ex_op;
  reg_idx_t add_ex_dest;
  data_t    add_ex_a;
  data_t    add_ex_b;
  logic     add_idle;
  logic     mul_ex_valid;
  opcode_e  mul_ex_op;
  reg_idx_t mul_ex_dest;
  data_t    mul_ex_a;
  data_t    mul_ex_b;
  logic     mul_idle;

  // unit to arbiter
  logic     add_res_valid;
  reg_idx_t add_res_reg;
  data_t    add_res_value;
  logic     add_grant;
  logic     mul_res_valid;
  reg_idx_t mul_res_reg;
  data_t    mul_res_value;
  logic     mul_grant;

  issue_decode issue_decode_inst (
    .clk(clk), .rst_n(rst_n),
    .instr_req(instr_req), .instr(instr), .instr_ack(instr_ack),
    .add_full(add_full), .mul_full(mul_full),
    .a_addr(a_addr), .b_addr(b_addr), .dest_addr(dest_addr),
    .a_value(a_value), .b_value(b_value),
    .a_busy(a_busy), .b_busy(b_busy), .dest_busy(dest_busy),
    .add_disp_valid(add_disp_valid), .mul_disp_valid(mul_disp_valid),
    .disp_op(disp_op), .disp_dest(disp_dest),
    .disp_a_reg(disp_a_reg), .disp_b_reg(disp_b_reg),
    .disp_a_value(disp_a_value), .disp_b_value(disp_b_value),
    .disp_a_busy(disp_a_busy), .disp_b_busy(disp_b_busy),
    .mark_valid(mark_valid), .mark_reg(mark_reg)
  );

  reg_status_file reg_status_file_inst (
    .clk(clk), .rst_n(rst_n),
    .a_addr(a_addr), .b_addr(b_addr), .dest_addr(dest_addr), .rd_addr(rd_addr),
    .mark_valid(mark_valid), .mark_reg(mark_reg),
    .cdb_valid(cdb_valid), .cdb_reg(cdb_reg), .cdb_value(cdb_value),
    .a_value(a_value), .b_value(b_value),
    .a_busy(a_busy), .b_busy(b_busy), .dest_busy(dest_busy),
    .rd_data(rd_data)
  );

  reservation_station #(.DEPTH(ADD_RS_DEPTH)) add_rs_inst (
    .clk(clk), .rst_n(rst_n),
    .disp_valid(add_disp_valid), .disp_op(disp_op), .disp_dest(disp_dest),
    .disp_a_reg(disp_a_reg), .disp_b_reg(disp_b_reg),
    .disp_a_value(disp_a_value), .disp_b_value(disp_b_value),
    .disp_a_busy(disp_a_busy), .disp_b_busy(disp_b_busy),
    .unit_idle(add_idle),
    .cdb_valid(cdb_valid), .cdb_reg(cdb_reg), .cdb_value(cdb_value),
    .full(add_full), .ex_valid(add_ex_valid), .ex_op(add_ex_op),
    .ex_dest(add_ex_dest), .ex_a(add_ex_a), .ex_b(add_ex_b)
  );

  reservation_station #(.DEPTH(MUL_RS_DEPTH)) mul_rs_inst (
    .clk(clk), .rst_n(rst_n),
    .disp_valid(mul_disp_valid), .disp_op(disp_op), .disp_dest(disp_dest),
    .disp_a_reg(disp_a_reg), .disp_b_reg(disp_b_reg),
    .disp_a_value(disp_a_value), .disp_b_value(disp_b_value),
    .disp_a_busy(disp_a_busy), .disp_b_busy(disp_b_busy),
    .unit_idle(mul_idle),
    .cdb_valid(cdb_valid), .cdb_reg(cdb_reg), .cdb_value(cdb_value),
    .full(mul_full), .ex_valid(mul_ex_valid), .ex_op(mul_ex_op),
    .ex_dest(mul_ex_dest), .ex_a(mul_ex_a), .ex_b(mul_ex_b)
  );

  fp_exec_unit #(.LATENCY(ADD_LATENCY)) add_unit_inst (
    .clk(clk), .rst_n(rst_n),
    .ex_valid(add_ex_valid), .ex_op(add_ex_op), .ex_dest(add_ex_dest),
    .ex_a(add_ex_a), .ex_b(add_ex_b), .res_grant(add_grant),
    .idle(add_idle), .res_valid(add_res_valid),
    .res_reg(add_res_reg), .res_value(add_res_value)
  );

  fp_exec_unit #(.LATENCY(MUL_LATENCY)) mul_unit_inst (
    .clk(clk), .rst_n(rst_n),
    .ex_valid(mul_ex_valid), .ex_op(mul_ex_op), .ex_dest(mul_ex_dest),
    .ex_a(mul_ex_a), .ex_b(mul_ex_b), .res_grant(mul_grant),
    .idle(mul_idle), .res_valid(mul_res_valid),
    .res_reg(mul_res_reg), .res_value(mul_res_value)
  );

  cdb_arbiter cdb_arbiter_inst (
    .clk(clk), .rst_n(rst_n),
    .add_res_valid(add_res_valid), .add_res_reg(add_res_reg),
    .add_res_value(add_res_value),
    .mul_res_valid(mul_res_valid), .mul_res_reg(mul_res_reg),
    .mul_res_value(mul_res_value),
    .add_grant(add_grant), .mul_grant(mul_grant),
    .cdb_valid(cdb_valid), .cdb_reg(cdb_reg), .cdb_value(cdb_value)
  );

endmodule

//--- logic/tomasulo_pkg.sv
// Tomasulo FP core shared definitions
// data and register widths, instruction word layout,
// unit latencies, station depths and the opcode encoding
package tomasulo_pkg;

  // register and bus value
  typedef logic [31:0] data_t;

  // register number, r0 is the constant zero register
  typedef logic [2:0] reg_idx_t;

  // raw instruction word
  // [11:9] opcode, [8:6] dest, [5:3] src a, [2:0] src b
  typedef logic [11:0] instr_t;

  // opcodes known to the core, anything else decodes as nop
  typedef enum logic [2:0] {
    op_nop   = 3'd0,
    op_addf  = 3'd3,
    op_multf = 3'd4
  } opcode_e;

  // register file size, including r0
  localparam int NUM_REGS = 8;

  // value loaded into r1..r7 at reset
  localparam data_t REG_RESET_VALUE = 32'd1;

  // cycles from accept to result in each unit
  localparam int ADD_LATENCY = 3;
  localparam int MUL_LATENCY = 5;

  // entries per reservation station
  localparam int ADD_RS_DEPTH = 3;
  localparam int MUL_RS_DEPTH = 2;

endpackage

//--- run.sh
#!/bin/sh
# build the Tomasulo core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_tomasulo -f flist.f -o sim_tomasulo

./obj_dir/sim_tomasulo > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
  echo "simulation reported failure"
  exit 1
fi
exit 0

//--- tests/tb_tomasulo.sv
// Testbench for the Tomasulo FP issue core
// sends instructions over the four-phase req/ack port, keeps an
// in-order reference model of the register file, matches every
// common data bus broadcast by register and checks final contents
`timescale 1ns/1ps

module tb_tomasulo import tomasulo_pkg::*; ();

  // instruction counts per test, used for the watchdog budget
  localparam int SINGLE_LEN = 1;
  localparam int CHAIN_LEN = 6;
  localparam int BP_LEN = 6;
  localparam int NOP_LEN = 3;
  localparam int RAND_LEN = 40;
  localparam int TOTAL_INSTR = SINGLE_LEN + CHAIN_LEN + BP_LEN + NOP_LEN + RAND_LEN;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 60;

  logic     clk;
  logic     rst_n;
  logic     instr_req;
  instr_t   instr;
  logic     instr_ack;
  logic     cdb_valid;
  reg_idx_t cdb_reg;
  data_t    cdb_value;
  reg_idx_t rd_addr;
  data_t    rd_data;

  // reference register file and pending broadcasts in program order
  data_t    model_regs [NUM_REGS];
  reg_idx_t pend_reg [$];
  data_t    pend_val [$];

  int seed;
  int errors;
  int tests_run;
  int tests_failed;
  int bcast_count;
  int push_count;
  int t_err0;
  int t_bc0;
  int t_push0;

  tomasulo_core tomasulo_core_inst (
    .clk(clk), .rst_n(rst_n),
    .instr_req(instr_req), .instr(instr), .instr_ack(instr_ack),
    .cdb_valid(cdb_valid), .cdb_reg(cdb_reg), .cdb_value(cdb_value),
    .rd_addr(rd_addr), .rd_data(rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // handshake rules, sampled on the rising edge
  assert property (@(posedge clk) disable iff (!rst_n) $rose(instr_ack) |-> $past(instr_req))
    else begin
      $display("** Error (%0t): instr_ack rose without a request", $time);
      errors++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) $fell(instr_ack) |-> !$past(instr_req))
    else begin
      $display("** Error (%0t): instr_ack fell while instr_req was still high", $time);
      errors++;
    end
  // r0 results are dropped in decode, never broadcast
  assert property (@(posedge clk) disable iff (!rst_n) cdb_valid |-> (cdb_reg != 3'd0))
    else begin
      $display("** Error (%0t): broadcast targets r0", $time);
      errors++;
    end

  // bus monitor, mid-cycle where the registered bus is stable
  always @(negedge clk) begin
    int idx;
    idx = -1;
    if (rst_n && cdb_valid) begin
      bcast_count++;
      // oldest pending result for this register
      for (int i = 0; i < pend_reg.size(); i++) begin
        if (idx < 0 && pend_reg[i] == cdb_reg) begin
          idx = i;
        end
      end
      if (idx < 0) begin
        $display("unexpected broadcast for r%0d at %0t, no result was pending", cdb_reg, $time);
        errors++;
      end else begin
        assert (cdb_value == pend_val[idx]) else begin
          $display("** Error (%0t): r%0d broadcast %h, expected %h",
                   $time, cdb_reg, cdb_value, pend_val[idx]);
          errors++;
        end
        pend_reg.delete(idx);
        pend_val.delete(idx);
      end
    end
  end

  // reference: ADDF wraps, MULTF keeps the low word, r0 discards
  function automatic void apply_model(input instr_t word);
    logic [2:0] op;
    reg_idx_t   d;
    reg_idx_t   a;
    reg_idx_t   b;
    data_t      v;
    op = word[11:9];
    d  = word[8:6];
    a  = word[5:3];
    b  = word[2:0];
    if ((op == 3'd3 || op == 3'd4) && d != 3'd0) begin
      v = (op == 3'd3) ? model_regs[a] + model_regs[b] : model_regs[a] * model_regs[b];
      model_regs[d] = v;
      pend_reg.push_back(d);
      pend_val.push_back(v);
      push_count++;
    end
  endfunction

  function automatic instr_t make_instr(input logic [2:0] op, input reg_idx_t d,
                                        input reg_idx_t a, input reg_idx_t b);
    return {op, d, a, b};
  endfunction

  // one full four-phase transfer
  task automatic send_instr(input instr_t word);
    @(negedge clk);
    instr_req = 1'b1;
    instr     = word;
    @(negedge clk);
    while (!instr_ack) @(negedge clk);
    apply_model(word);
    instr_req = 1'b0;
    @(negedge clk);
    while (instr_ack) @(negedge clk);
  endtask

  // wait until every expected result went out, then a quiet window
  task automatic drain(input int max_cycles);
    int waited;
    waited = 0;
    while (pend_reg.size() != 0 && waited < max_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (pend_reg.size() != 0) begin
      $display("%0d expected results never reached the bus by %0t", pend_reg.size(), $time);
      errors++;
    end
    // catches stray or repeated broadcasts
    repeat (12) @(negedge clk);
  endtask

  task automatic check_reg(input int r, input data_t exp);
    @(negedge clk);
    rd_addr = reg_idx_t'(r);
    #1;
    assert (rd_data == exp) else begin
      $display("** Error (%0t): r%0d reads %h, expected %h", $time, r, rd_data, exp);
      errors++;
    end
  endtask

  task automatic check_all_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
      check_reg(r, model_regs[r]);
    end
  endtask

  task automatic begin_test();
    t_err0  = errors;
    t_bc0   = bcast_count;
    t_push0 = push_count;
  endtask

  task automatic end_test(input string name);
    assert (bcast_count - t_bc0 == push_count - t_push0) else begin
      $display("** Error (%0t): %s saw %0d broadcasts, expected %0d",
               $time, name, bcast_count - t_bc0, push_count - t_push0);
      errors++;
    end
    tests_run++;
    if (errors == t_err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED", name);
    end
  endtask

  // ends a hung run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the core stopped responding", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    logic [2:0]  op;
    seed         = 22;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    bcast_count  = 0;
    push_count   = 0;
    rst_n        = 1'b0;
    instr_req    = 1'b0;
    instr        = '0;
    rd_addr      = '0;
    model_regs[0] = 32'd0;
    for (int r = 1; r < NUM_REGS; r++) begin
      model_regs[r] = 32'd1;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // reset state
    begin_test();
    @(negedge clk);
    assert (!instr_ack && !cdb_valid) else begin
      $display("** Error (%0t): instr_ack or cdb_valid high after reset", $time);
      errors++;
    end
    check_all_regs();
    end_test("reset");

    // r1 + r1 into r2
    begin_test();
    send_instr(make_instr(op_addf, 3'd2, 3'd1, 3'd1));
    drain(60 * SINGLE_LEN);
    check_reg(2, 32'd2);
    end_test("single add");

    // RAW chain across both units, last two reuse r3
    begin_test();
    send_instr(make_instr(op_multf, 3'd3, 3'd2, 3'd2));
    send_instr(make_instr(op_addf, 3'd4, 3'd3, 3'd1));
    send_instr(make_instr(op_multf, 3'd5, 3'd4, 3'd3));
    send_instr(make_instr(op_addf, 3'd6, 3'd5, 3'd4));
    send_instr(make_instr(op_addf, 3'd3, 3'd6, 3'd6));
    send_instr(make_instr(op_multf, 3'd7, 3'd3, 3'd2));
    drain(60 * CHAIN_LEN);
    check_all_regs();
    end_test("dependent chain");

    // adds pile up behind the multiply and fill the add station
    begin_test();
    send_instr(make_instr(op_multf, 3'd1, 3'd7, 3'd7));
    send_instr(make_instr(op_addf, 3'd2, 3'd1, 3'd1));
    send_instr(make_instr(op_addf, 3'd3, 3'd2, 3'd1));
    send_instr(make_instr(op_addf, 3'd4, 3'd3, 3'd1));
    send_instr(make_instr(op_addf, 3'd5, 3'd4, 3'd2));
    send_instr(make_instr(op_addf, 3'd6, 3'd5, 3'd1));
    drain(60 * BP_LEN);
    check_all_regs();
    end_test("back-pressure");

    // plain nop, add into r0, unknown opcode
    begin_test();
    send_instr(make_instr(op_nop, 3'd3, 3'd1, 3'd2));
    send_instr(make_instr(op_addf, 3'd0, 3'd1, 3'd2));
    send_instr(make_instr(3'd7, 3'd4, 3'd5, 3'd6));
    drain(60 * NOP_LEN);
    check_reg(0, 32'd0);
    check_all_regs();
    end_test("nop and r0");

    // destinations limited to r0..r4 to force WAW reuse
    begin_test();
    for (int n = 0; n < RAND_LEN; n++) begin
      rnd = $random(seed);
      case (rnd[1:0])
        2'd0:    op = op_addf;
        2'd1:    op = op_multf;
        2'd2:    op = op_nop;
        default: op = 3'd6;
      endcase
      send_instr(make_instr(op, reg_idx_t'(rnd[31:8] % 5), rnd[7:5], rnd[4:2]));
    end
    drain(60 * RAND_LEN);
    check_all_regs();
    end_test("random program");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
